// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert -Wno-fatal
TOP       := cnn_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: all run check clean

all: check

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@! grep -q "STATUS: FAIL" $(LOG)

check: run
	@grep -q "STATUS: PASS" $(LOG)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/cnn_macros.svh ====
`ifndef CNN_MACROS_SVH
`define CNN_MACROS_SVH

// Picture, core and pool window sides
`define PIC_SIZE 8
`define CORE_SIZE 3
`define POOL_SIZE 2

// Right shift after the bias add
`define ACC_SHIFT 4

// Picture, core, bias and result files back to back
`define MEM_DEPTH 83

// Host header bytes
`define HDR_WRITE 8'd87
`define HDR_READ 8'd82
`define HDR_CALC 8'd67

`endif

// ==== design/cnn_pkg.sv ====
`include "cnn_macros.svh"

package cnn_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [6:0] mem_addr_t;

    typedef enum logic [1:0] {
        FILE_PICTURE,
        FILE_CORE,
        FILE_BIAS,
        FILE_RESULT
    } file_id_t;

    // One write request into the feature memory
    typedef struct packed {
        logic      en;
        mem_addr_t addr;
        byte_t     data;
    } mem_wr_t;

    function automatic mem_addr_t file_base(file_id_t f);
        case (f)
            FILE_PICTURE: return '0;
            FILE_CORE:    return mem_addr_t'(`PIC_SIZE * `PIC_SIZE);
            FILE_BIAS:    return mem_addr_t'(`PIC_SIZE * `PIC_SIZE + `CORE_SIZE * `CORE_SIZE);
            default:      return mem_addr_t'(`PIC_SIZE * `PIC_SIZE + `CORE_SIZE * `CORE_SIZE + 1);
        endcase
    endfunction

    // Each file ends right before the next one starts
    function automatic mem_addr_t file_last(file_id_t f);
        case (f)
            FILE_PICTURE: return file_base(FILE_CORE) - 1'b1;
            FILE_CORE:    return file_base(FILE_BIAS) - 1'b1;
            FILE_BIAS:    return file_base(FILE_RESULT) - 1'b1;
            default:      return mem_addr_t'(`MEM_DEPTH - 1);
        endcase
    endfunction

endpackage

// ==== design/cnn_top.sv ====
module cnn_top import cnn_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  byte_t rx_data,
    input  logic  rx_rdy,
    output byte_t tx_data,
    output logic  tx_en,
    input  logic  tx_busy,
    output logic  fin
);
    mem_wr_t   host_wr;
    mem_wr_t   calc_wr;
    logic      calc_start;
    logic      calc_busy;
    logic      read_start;
    file_id_t  read_file;
    logic      tx_active;
    mem_addr_t rd_addr_a;
    mem_addr_t rd_addr_b;
    byte_t     rd_data_a;
    byte_t     rd_data_b;

    host_command_rx host_command_rx_i (
        .clk        (clk),
        .reset      (reset),
        .rx_data    (rx_data),
        .rx_rdy     (rx_rdy),
        .calc_busy  (calc_busy),
        .tx_active  (tx_active),
        .host_wr    (host_wr),
        .calc_start (calc_start),
        .read_start (read_start),
        .read_file  (read_file)
    );

    feature_memory feature_memory_i (
        .clk       (clk),
        .host_wr   (host_wr),
        .calc_wr   (calc_wr),
        .rd_addr_a (rd_addr_a),
        .rd_data_a (rd_data_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_b (rd_data_b)
    );

    conv_engine conv_engine_i (
        .clk        (clk),
        .reset      (reset),
        .calc_start (calc_start),
        .calc_busy  (calc_busy),
        .fin        (fin),
        .rd_addr_a  (rd_addr_a),
        .rd_data_a  (rd_data_a),
        .calc_wr    (calc_wr)
    );

    file_reply_tx file_reply_tx_i (
        .clk        (clk),
        .reset      (reset),
        .read_start (read_start),
        .read_file  (read_file),
        .tx_active  (tx_active),
        .rd_addr_b  (rd_addr_b),
        .rd_data_b  (rd_data_b),
        .tx_data    (tx_data),
        .tx_en      (tx_en),
        .tx_busy    (tx_busy)
    );

endmodule

// ==== design/conv_engine.sv ====
`include "cnn_macros.svh"

module conv_engine import cnn_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      calc_start,
    output logic      calc_busy,
    output logic      fin,
    output mem_addr_t rd_addr_a,
    input  byte_t     rd_data_a,
    output mem_wr_t   calc_wr
);
    localparam int TAPS = `CORE_SIZE * `CORE_SIZE;
    localparam int POOL_OUT = (`PIC_SIZE - `CORE_SIZE + 1) / `POOL_SIZE;

    typedef enum logic [2:0] {ST_IDLE, ST_LOAD, ST_CONV, ST_DRAIN, ST_WRITE} state_t;

    state_t      state;
    logic        fin_q;
    logic [3:0]  ld_cnt;
    logic [3:0]  ld_idx;
    logic        ld_vld;
    logic [1:0]  pool_r;
    logic [1:0]  pool_c;
    logic        win_r;
    logic        win_c;
    logic [1:0]  tap_r;
    logic [1:0]  tap_c;
    logic [3:0]  tap_d;
    logic        px_vld;
    logic        px_last;
    logic [2:0]  pix_row;
    logic [2:0]  pix_col;
    logic [15:0] prod;
    logic [19:0] acc;
    logic [19:0] acc_sum;
    logic [19:0] biased;
    logic [19:0] shifted;
    byte_t       conv_val;
    byte_t       pool_max;
    byte_t       bias;
    byte_t       core_w [0:TAPS-1];

    assign calc_busy = (state != ST_IDLE);
    // Drops in the same cycle as the start pulse
    assign fin = fin_q && !calc_start;

    assign pix_row = 3'(pool_r * `POOL_SIZE + win_r + tap_r);
    assign pix_col = 3'(pool_c * `POOL_SIZE + win_c + tap_c);
    assign rd_addr_a = (state == ST_LOAD) ? file_base(FILE_CORE) + mem_addr_t'(ld_cnt)
                                          : mem_addr_t'(pix_row * `PIC_SIZE + pix_col);

    // Last tap folds in combinationally during the drain cycle
    assign prod = rd_data_a * core_w[tap_d];
    assign acc_sum = acc + 20'(prod);
    assign biased = acc_sum + 20'(bias);
    assign shifted = biased >> `ACC_SHIFT;
    assign conv_val = (shifted > 20'd255) ? 8'hff : shifted[7:0];

    always_comb begin
        calc_wr.en = (state == ST_WRITE);
        calc_wr.addr = file_base(FILE_RESULT) + mem_addr_t'(pool_r * POOL_OUT + pool_c);
        calc_wr.data = pool_max;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            fin_q <= 1'b0;
            ld_cnt <= '0;
            ld_vld <= 1'b0;
            px_vld <= 1'b0;
            acc <= '0;
            pool_max <= '0;
            pool_r <= '0;
            pool_c <= '0;
            win_r <= 1'b0;
            win_c <= 1'b0;
            tap_r <= '0;
            tap_c <= '0;
        end else begin
            ld_vld <= (state == ST_LOAD);
            px_vld <= (state == ST_CONV);
            if (px_vld) begin
                acc <= px_last ? '0 : acc_sum;
            end
            case (state)
                ST_IDLE: begin
                    if (calc_start) begin
                        fin_q <= 1'b0;
                        ld_cnt <= '0;
                        pool_max <= '0;
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    // Nine core bytes and then the bias
                    ld_cnt <= ld_cnt + 1'b1;
                    if (ld_cnt == TAPS) begin
                        state <= ST_CONV;
                    end
                end
                ST_CONV: begin
                    if (tap_c == `CORE_SIZE - 1) begin
                        tap_c <= '0;
                        if (tap_r == `CORE_SIZE - 1) begin
                            tap_r <= '0;
                            state <= ST_DRAIN;
                        end else begin
                            tap_r <= tap_r + 1'b1;
                        end
                    end else begin
                        tap_c <= tap_c + 1'b1;
                    end
                end
                ST_DRAIN: begin
                    if (conv_val > pool_max) begin
                        pool_max <= conv_val;
                    end
                    win_c <= ~win_c;
                    state <= ST_CONV;
                    if (win_c) begin
                        win_r <= ~win_r;
                        if (win_r) begin
                            state <= ST_WRITE;
                        end
                    end
                end
                ST_WRITE: begin
                    pool_max <= '0;
                    state <= ST_CONV;
                    if (pool_c == POOL_OUT - 1) begin
                        pool_c <= '0;
                        if (pool_r == POOL_OUT - 1) begin
                            pool_r <= '0;
                            fin_q <= 1'b1;
                            state <= ST_IDLE;
                        end else begin
                            pool_r <= pool_r + 1'b1;
                        end
                    end else begin
                        pool_c <= pool_c + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Tags that travel with each read, and the loaded weights
    always_ff @(posedge clk) begin
        ld_idx <= ld_cnt;
        tap_d <= 4'(tap_r * `CORE_SIZE + tap_c);
        px_last <= (tap_r == `CORE_SIZE - 1) && (tap_c == `CORE_SIZE - 1);
        if (ld_vld) begin
            if (ld_idx == TAPS) begin
                bias <= rd_data_a;
            end else begin
                core_w[ld_idx] <= rd_data_a;
            end
        end
    end

    a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
        calc_start |-> !calc_busy);

endmodule

// ==== design/feature_memory.sv ====
`include "cnn_macros.svh"

module feature_memory import cnn_pkg::*; (
    input  logic      clk,
    input  mem_wr_t   host_wr,
    input  mem_wr_t   calc_wr,
    input  mem_addr_t rd_addr_a,
    output byte_t     rd_data_a,
    input  mem_addr_t rd_addr_b,
    output byte_t     rd_data_b
);
    byte_t   mem [0:`MEM_DEPTH-1];
    mem_wr_t wr;

    // Host and engine never write in the same cycle
    assign wr = host_wr.en ? host_wr : calc_wr;

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
        rd_data_a <= mem[rd_addr_a];
        rd_data_b <= mem[rd_addr_b];
    end

    a_single_writer: assert property (@(posedge clk)
        !(host_wr.en && calc_wr.en));

endmodule

// ==== design/file_reply_tx.sv ====
module file_reply_tx import cnn_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      read_start,
    input  file_id_t  read_file,
    output logic      tx_active,
    output mem_addr_t rd_addr_b,
    input  byte_t     rd_data_b,
    output byte_t     tx_data,
    output logic      tx_en,
    input  logic      tx_busy
);
    typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_SEND, ST_PULSE} state_t;

    state_t    state;
    mem_addr_t last_addr;

    assign tx_active = (state != ST_IDLE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            rd_addr_b <= '0;
            last_addr <= '0;
            tx_en <= 1'b0;
        end else begin
            tx_en <= (state == ST_SEND) && !tx_busy;
            case (state)
                ST_IDLE: begin
                    if (read_start) begin
                        rd_addr_b <= file_base(read_file);
                        last_addr <= file_last(read_file);
                        state <= ST_FETCH;
                    end
                end
                // Memory read lands here, and the link raises busy after a pulse
                ST_FETCH: state <= ST_SEND;
                ST_SEND: begin
                    if (!tx_busy) begin
                        state <= ST_PULSE;
                    end
                end
                default: begin
                    if (rd_addr_b == last_addr) begin
                        state <= ST_IDLE;
                    end else begin
                        rd_addr_b <= rd_addr_b + 1'b1;
                        state <= ST_FETCH;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_SEND) begin
            tx_data <= rd_data_b;
        end
    end

    a_no_send_busy: assert property (@(posedge clk) disable iff (reset)
        tx_en |-> !tx_busy);

endmodule

// ==== design/host_command_rx.sv ====
`include "cnn_macros.svh"

module host_command_rx import cnn_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  byte_t    rx_data,
    input  logic     rx_rdy,
    input  logic     calc_busy,
    input  logic     tx_active,
    output mem_wr_t  host_wr,
    output logic     calc_start,
    output logic     read_start,
    output file_id_t read_file
);
    typedef enum logic [1:0] {ST_HDR, ST_IDX_HI, ST_IDX_LO, ST_DATA} state_t;

    state_t    state;
    logic      is_write;
    logic      hi_zero;
    logic      accept;
    logic      idx_ok;
    file_id_t  idx_file;
    mem_addr_t wr_addr;
    mem_addr_t last_addr;

    // Bytes are dropped while the engine or the transmitter owns the memory
    assign accept = rx_rdy && !calc_busy && !tx_active;
    assign idx_ok = hi_zero && (rx_data[7:2] == '0);
    assign idx_file = file_id_t'(rx_data[1:0]);

    always_comb begin
        host_wr.en = accept && (state == ST_DATA);
        host_wr.addr = wr_addr;
        host_wr.data = rx_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_HDR;
            is_write <= 1'b0;
            hi_zero <= 1'b0;
            wr_addr <= '0;
            last_addr <= '0;
            calc_start <= 1'b0;
            read_start <= 1'b0;
            read_file <= FILE_PICTURE;
        end else begin
            calc_start <= 1'b0;
            read_start <= 1'b0;
            if (accept) begin
                case (state)
                    ST_HDR: begin
                        case (rx_data)
                            `HDR_WRITE: begin
                                is_write <= 1'b1;
                                state <= ST_IDX_HI;
                            end
                            `HDR_READ: begin
                                is_write <= 1'b0;
                                state <= ST_IDX_HI;
                            end
                            `HDR_CALC: calc_start <= 1'b1;
                            default: ;
                        endcase
                    end
                    ST_IDX_HI: begin
                        hi_zero <= (rx_data == '0);
                        state <= ST_IDX_LO;
                    end
                    ST_IDX_LO: begin
                        state <= ST_HDR;
                        if (idx_ok && is_write) begin
                            wr_addr <= file_base(idx_file);
                            last_addr <= file_last(idx_file);
                            state <= ST_DATA;
                        end else if (idx_ok) begin
                            read_start <= 1'b1;
                            read_file <= idx_file;
                        end
                    end
                    default: begin
                        wr_addr <= wr_addr + 1'b1;
                        if (wr_addr == last_addr) begin
                            state <= ST_HDR;
                        end
                    end
                endcase
            end
        end
    end

    // Host writes stay inside the file being written
    a_write_in_file: assert property (@(posedge clk) disable iff (reset)
        host_wr.en |-> (host_wr.addr <= last_addr));

endmodule

// ==== project.f ====
+incdir+design
design/cnn_pkg.sv
design/host_command_rx.sv
design/feature_memory.sv
design/conv_engine.sv
design/file_reply_tx.sv
design/cnn_top.sv
testbench/cnn_tb.sv

// ==== testbench/cnn_tb.sv ====
`include "cnn_macros.svh"

module cnn_tb import cnn_pkg::*; ();
    localparam int CLK_PERIOD = 40;
    localparam int NUM_ROWS = 5;
    localparam int PIC_BYTES = `PIC_SIZE * `PIC_SIZE;
    localparam int CORE_BYTES = `CORE_SIZE * `CORE_SIZE;
    localparam int POOL_OUT = (`PIC_SIZE - `CORE_SIZE + 1) / `POOL_SIZE;
    localparam int RES_BYTES = POOL_OUT * POOL_OUT;
    // Cycles for one row of writes, reads and one compute plus margin
    localparam int ROW_CYCLES = 5000;
    localparam int COMPUTE_LIMIT = 2000;

    typedef struct packed {
        logic            rand_pic;
        logic [0:8][7:0] core;
        logic [7:0]      bias;
        logic [3:0]      busy_len;
    } row_t;

    logic   clk;
    logic   reset;
    byte_t  rx_data;
    logic   rx_rdy;
    byte_t  tx_data;
    logic   tx_en;
    logic   tx_busy;
    logic   fin;

    row_t   rows [0:NUM_ROWS-1];
    byte_t  pic [0:PIC_BYTES-1];
    byte_t  core_b [0:CORE_BYTES-1];
    byte_t  bias_b;
    byte_t  exp_res [0:RES_BYTES-1];
    byte_t  exp_q [$];
    byte_t  got_q [$];
    int     busy_len;
    int     errors;
    int     checks;
    integer seed;

    cnn_top cnn_top_i (
        .clk     (clk),
        .reset   (reset),
        .rx_data (rx_data),
        .rx_rdy  (rx_rdy),
        .tx_data (tx_data),
        .tx_en   (tx_en),
        .tx_busy (tx_busy),
        .fin     (fin)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Link model raises busy on the cycle after each pulse
    initial begin
        tx_busy = 1'b0;
        forever begin
            @(negedge clk);
            if (tx_en === 1'b1) begin
                got_q.push_back(tx_data);
                @(negedge clk);
                tx_busy = 1'b1;
                repeat (busy_len) begin
                    @(negedge clk);
                    checks++;
                    if (tx_en !== 1'b0) begin
                        errors++;
                        $display("[ERROR] tx_en = %h while tx_busy = 1, expected 0", tx_en);
                    end
                end
                tx_busy = 1'b0;
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (NUM_ROWS * ROW_CYCLES + 100));
        $display("Watchdog timeout: the test sequence did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic send_byte(input byte_t b);
        integer rnd;
        rx_data = b;
        rx_rdy = 1'b1;
        @(negedge clk);
        rx_rdy = 1'b0;
        rnd = $random(seed);
        repeat (rnd[1:0]) @(negedge clk);
    endtask

    task automatic send_cmd(input byte_t hdr, input int idx);
        send_byte(hdr);
        send_byte(8'h00);
        send_byte(idx[7:0]);
    endtask

    // Expected contents of one file from the host copy
    task automatic fill_expected(input int fid);
        exp_q.delete();
        case (fid)
            0: for (int k = 0; k < PIC_BYTES; k++) exp_q.push_back(pic[k]);
            1: for (int k = 0; k < CORE_BYTES; k++) exp_q.push_back(core_b[k]);
            2: exp_q.push_back(bias_b);
            default: for (int k = 0; k < RES_BYTES; k++) exp_q.push_back(exp_res[k]);
        endcase
    endtask

    task automatic write_file(input int fid);
        fill_expected(fid);
        send_cmd(`HDR_WRITE, fid);
        while (exp_q.size() > 0) begin
            send_byte(exp_q.pop_front());
        end
    endtask

    task automatic read_check(input int fid);
        int count;
        int waited;
        fill_expected(fid);
        count = exp_q.size();
        got_q.delete();
        send_cmd(`HDR_READ, fid);
        waited = 0;
        while (got_q.size() < count && waited < count * 20 + 50) begin
            @(negedge clk);
            waited++;
        end
        // Room for stray extra bytes to show up
        repeat (busy_len + 8) @(negedge clk);
        checks++;
        if (got_q.size() != count) begin
            errors++;
            $display("Read of file %0d returned %0d bytes instead of %0d",
                fid, got_q.size(), count);
        end
        for (int k = 0; k < count && k < got_q.size(); k++) begin
            check_value($sformatf("tx_data (file %0d byte %0d)", fid, k), got_q[k], exp_q[k]);
        end
    endtask

    // Convolution, bias, shift and clamp, then 2x2 max pool
    task automatic compute_model();
        int sum;
        int best;
        int r;
        int c;
        for (int pr = 0; pr < POOL_OUT; pr++) begin
            for (int pc = 0; pc < POOL_OUT; pc++) begin
                best = 0;
                for (int w = 0; w < `POOL_SIZE * `POOL_SIZE; w++) begin
                    r = pr * `POOL_SIZE + w / `POOL_SIZE;
                    c = pc * `POOL_SIZE + w % `POOL_SIZE;
                    sum = bias_b;
                    for (int t = 0; t < CORE_BYTES; t++) begin
                        sum += pic[(r + t / `CORE_SIZE) * `PIC_SIZE + c + t % `CORE_SIZE]
                            * core_b[t];
                    end
                    sum = sum >> `ACC_SHIFT;
                    if (sum > 255) sum = 255;
                    if (sum > best) best = sum;
                end
                exp_res[pr * POOL_OUT + pc] = best[7:0];
            end
        end
    endtask

    task automatic run_compute(input int row);
        int waited;
        if (row > 0) check_value("fin", {7'b0, fin}, 8'h01);
        send_byte(`HDR_CALC);
        check_value("fin", {7'b0, fin}, 8'h00);
        waited = 0;
        while (fin !== 1'b1 && waited < COMPUTE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        if (fin !== 1'b1) begin
            errors++;
            $display("fin did not rise within %0d cycles of the compute command", COMPUTE_LIMIT);
        end
    endtask

    task automatic run_row(input int row);
        integer rnd;
        busy_len = rows[row].busy_len;
        for (int k = 0; k < PIC_BYTES; k++) begin
            rnd = $random(seed);
            pic[k] = rows[row].rand_pic ? rnd[7:0] : 8'hff;
        end
        for (int k = 0; k < CORE_BYTES; k++) core_b[k] = rows[row].core[k];
        bias_b = rows[row].bias;
        compute_model();
        for (int f = 0; f < 3; f++) write_file(f);
        for (int f = 0; f < 3; f++) read_check(f);
        if (row == 1) begin
            // Unknown header, then a write to file 5 and loose bytes
            send_byte(8'h58);
            send_cmd(`HDR_WRITE, 5);
            send_byte(8'h11);
            send_byte(8'h22);
            send_byte(8'h33);
            read_check(0);
        end
        run_compute(row);
        read_check(3);
    endtask

    initial begin
        seed = 32'hf851;
        errors = 0;
        checks = 0;
        busy_len = 1;
        reset = 1'b1;
        rx_data = '0;
        rx_rdy = 1'b0;
        rows[0] = '{1'b1, {8'd1, 8'd2, 8'd1, 8'd2, 8'd4, 8'd2, 8'd1, 8'd2, 8'd1}, 8'd5, 4'd1};
        rows[1] = '{1'b1, {8'd0, 8'd1, 8'd0, 8'd1, 8'd3, 8'd1, 8'd0, 8'd1, 8'd0}, 8'd200, 4'd4};
        rows[2] = '{1'b0, {9{8'd16}}, 8'd9, 4'd12};
        rows[3] = '{1'b1, {8'd2, 8'd5, 8'd0, 8'd7, 8'd1, 8'd3, 8'd0, 8'd4, 8'd2}, 8'd0, 4'd7};
        rows[4] = '{1'b1, {8'd0, 8'd0, 8'd0, 8'd0, 8'd16, 8'd0, 8'd0, 8'd0, 8'd0}, 8'd15, 4'd2};
        repeat (5) @(negedge clk);
        reset = 1'b0;
        check_value("tx_en", {7'b0, tx_en}, 8'h00);
        check_value("fin", {7'b0, fin}, 8'h00);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
